// ==== busDatapathPkg.sv ====
// shared widths and encodings for the bus datapath RTL and its testbench, referenced by scope
package busDatapathPkg;

  parameter int dataWidth = 32;       // bus and register width
  parameter int defaultRegCount = 8;  // general registers, 16 also works

  typedef logic [dataWidth-1:0] wordT;

  // Z register contents, high half in the upper bits
  typedef struct packed {
    wordT hi;
    wordT lo;
  } wideT;

  typedef enum logic [4:0] {
    aluAdd  = 5'b00011,
    aluSub  = 5'b00100,
    aluAnd  = 5'b00101,
    aluOr   = 5'b00110,
    aluShr  = 5'b00111,
    aluShra = 5'b01000,
    aluShl  = 5'b01001,
    aluRor  = 5'b01010,
    aluRol  = 5'b01011,
    aluMul  = 5'b01111,
    aluDiv  = 5'b10000,
    aluNeg  = 5'b10001,
    aluNot  = 5'b10010
  } aluOpT;

  typedef enum logic [1:0] {
    srcReg   = 2'd0,  // selected general register
    srcMdr   = 2'd1,
    srcZLow  = 2'd2,
    srcZHigh = 2'd3
  } busSourceT;

  typedef enum logic {
    cmdLoad    = 1'b0,
    cmdOperate = 1'b1
  } cmdKindT;

endpackage

// ==== busCtrlIf.sv ====
// step controls and the shared bus word, passed from the sequencer to registers, mux and ALU
`timescale 1ns/1ns

interface busCtrlIf #(
  parameter int regCount = busDatapathPkg::defaultRegCount
);

  busDatapathPkg::busSourceT   busSource;  // who drives the bus this cycle
  logic [$clog2(regCount)-1:0] regSelect;  // register index when busSource is srcReg
  logic [regCount-1:0]         regLoad;    // one-hot, loads on the ending edge
  logic                        yLoad;
  logic                        zLoad;
  busDatapathPkg::aluOpT       aluOp;
  busDatapathPkg::wordT        bus;

  modport sequencer (
    output busSource, regSelect, regLoad, yLoad, zLoad, aluOp
  );

  modport regs (
    input regLoad, bus
  );

  modport mux (
    input busSource, regSelect,
    output bus
  );

  modport alu (
    input yLoad, zLoad, aluOp, bus
  );

endinterface

// ==== gpRegister.sv ====
// one general purpose register, written from the bus when its bit of the load vector is set
`timescale 1ns/1ns

module gpRegister (
  input  logic                 clock,
  input  logic                 arstN,
  input  logic                 load,   // this register's regLoad bit
  input  busDatapathPkg::wordT bus,
  output busDatapathPkg::wordT value
);

  busDatapathPkg::wordT regQ;

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      regQ <= '0;               // registers come up as zero
    end else if (load) begin
      regQ <= bus;
    end
  end

  assign value = regQ;

endmodule

// ==== busMux.sv ====
// bus source selection; picks one register, the MDR or a half of Z to drive the shared bus
`timescale 1ns/1ns

module busMux #(
  parameter int regCount = busDatapathPkg::defaultRegCount
) (
  busCtrlIf.mux         ctrl,
  input  busDatapathPkg::wordT regValues [regCount],
  input  busDatapathPkg::wordT mdr,
  input  busDatapathPkg::wideT zValue
);

  busDatapathPkg::wordT busWord;

  always_comb begin
    case (ctrl.busSource)
      busDatapathPkg::srcReg: begin
        busWord = regValues[ctrl.regSelect];
      end
      busDatapathPkg::srcMdr: begin
        busWord = mdr;
      end
      busDatapathPkg::srcZLow: begin
        busWord = zValue.lo;
      end
      default: begin
        busWord = zValue.hi;  // srcZHigh, second word of mul/div
      end
    endcase
  end

  assign ctrl.bus = busWord;

endmodule

// ==== aluUnit.sv ====
// Y operand register, the ALU and the 64-bit Z result register on the shared bus
`timescale 1ns/1ns

module aluUnit (
  input  logic                 clock,
  input  logic                 arstN,
  busCtrlIf.alu                ctrl,
  output busDatapathPkg::wideT zValue
);

  localparam int w = busDatapathPkg::dataWidth;

  busDatapathPkg::wordT yReg;      // first operand, bus is the second
  busDatapathPkg::wideT zReg;
  busDatapathPkg::wideT result;
  logic [4:0]           shamt;
  logic [2*w-1:0]       product;
  logic [2*w-1:0]       yTwice;    // Y next to itself for rotates
  logic [2*w-1:0]       rotRight;
  logic [2*w-1:0]       rotLeft;

  assign shamt    = ctrl.bus[4:0];  // only the low five bits count
  assign product  = {{w{1'b0}}, yReg} * {{w{1'b0}}, ctrl.bus};
  assign yTwice   = {yReg, yReg};
  assign rotRight = yTwice >> shamt;
  assign rotLeft  = yTwice << shamt;

  always_comb begin
    result = '0;  // Z high stays zero unless mul or div
    case (ctrl.aluOp)
      busDatapathPkg::aluAnd:  result.lo = yReg & ctrl.bus;
      busDatapathPkg::aluOr:   result.lo = yReg | ctrl.bus;
      busDatapathPkg::aluAdd:  result.lo = yReg + ctrl.bus;
      busDatapathPkg::aluSub:  result.lo = yReg - ctrl.bus;
      busDatapathPkg::aluShr:  result.lo = yReg >> shamt;
      busDatapathPkg::aluShra: result.lo = $signed(yReg) >>> shamt;
      busDatapathPkg::aluShl:  result.lo = yReg << shamt;
      busDatapathPkg::aluRor:  result.lo = rotRight[w-1:0];
      busDatapathPkg::aluRol:  result.lo = rotLeft[2*w-1:w];
      busDatapathPkg::aluNeg:  result.lo = -ctrl.bus;
      busDatapathPkg::aluNot:  result.lo = ~ctrl.bus;
      busDatapathPkg::aluMul:  result = product;
      busDatapathPkg::aluDiv: begin
        if (ctrl.bus == '0) begin
          result.lo = '1;         // divide by zero, all-ones quotient
          result.hi = yReg;       // and the dividend back as remainder
        end else begin
          result.lo = yReg / ctrl.bus;
          result.hi = yReg % ctrl.bus;
        end
      end
      default: result = '0;
    endcase
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      yReg <= '0;
    end else if (ctrl.yLoad) begin
      yReg <= ctrl.bus;
    end
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      zReg <= '0;
    end else if (ctrl.zLoad) begin
      zReg <= result;
    end
  end

  assign zValue = zReg;

endmodule

// ==== controlSequencer.sv ====
// command intake, MDR and step FSM that drives the bus controls for loads and ALU operations
`timescale 1ns/1ns

module controlSequencer #(
  parameter int regCount = busDatapathPkg::defaultRegCount
) (
  input  logic                          clock,
  input  logic                          arstN,
  input  logic                          cmdValid,
  input  busDatapathPkg::cmdKindT       cmdKind,
  input  busDatapathPkg::aluOpT         cmdOp,
  input  logic [$clog2(regCount)-1:0]   cmdSrcA,
  input  logic [$clog2(regCount)-1:0]   cmdSrcB,
  input  logic [$clog2(regCount)-1:0]   cmdDst,
  input  logic [$clog2(regCount)-1:0]   cmdDstHi,
  input  busDatapathPkg::wordT          cmdData,
  output logic                          busy,
  busCtrlIf.sequencer                   ctrl,
  output logic                          writeValid,
  output logic [$clog2(regCount)-1:0]   writeIndex,
  output busDatapathPkg::wordT          mdr
);

  localparam int idxWidth = $clog2(regCount);

  typedef enum logic [2:0] {
    stIdle,
    stLoadWr,  // MDR onto the bus into dst
    stOpA,     // srcA into Y
    stOpB,     // srcB through the ALU into Z
    stOpLo,    // Z low into dst
    stOpHi     // Z high into dstHi, mul and div only
  } stepT;

  stepT                  step;
  stepT                  stepNext;
  busDatapathPkg::aluOpT opReg;
  logic [idxWidth-1:0]   srcAReg;
  logic [idxWidth-1:0]   srcBReg;
  logic [idxWidth-1:0]   dstReg;
  logic [idxWidth-1:0]   dstHiReg;
  busDatapathPkg::wordT  mdrReg;
  logic [regCount-1:0]   loadVec;
  logic                  accept;
  logic                  twoWord;

  assign busy    = (step != stIdle);
  assign accept  = cmdValid && !busy;
  assign twoWord = (opReg == busDatapathPkg::aluMul) || (opReg == busDatapathPkg::aluDiv);

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      opReg    <= busDatapathPkg::aluAnd;
      srcAReg  <= '0;
      srcBReg  <= '0;
      dstReg   <= '0;
      dstHiReg <= '0;
      mdrReg   <= '0;
    end else if (accept) begin
      opReg    <= cmdOp;
      srcAReg  <= cmdSrcA;
      srcBReg  <= cmdSrcB;
      dstReg   <= cmdDst;
      dstHiReg <= cmdDstHi;
      if (cmdKind == busDatapathPkg::cmdLoad) begin
        mdrReg <= cmdData;  // MDR only changes on a load
      end
    end
  end

  always_comb begin
    stepNext = step;
    case (step)
      stIdle: begin
        if (accept) begin
          stepNext = (cmdKind == busDatapathPkg::cmdLoad) ? stLoadWr : stOpA;
        end
      end
      stLoadWr: stepNext = stIdle;
      stOpA:    stepNext = stOpB;
      stOpB:    stepNext = stOpLo;
      stOpLo:   stepNext = twoWord ? stOpHi : stIdle;
      default:  stepNext = stIdle;
    endcase
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      step <= stIdle;
    end else begin
      step <= stepNext;
    end
  end

  // step decode; the load vector doubles as the write event
  always_comb begin
    ctrl.busSource = busDatapathPkg::srcReg;
    ctrl.regSelect = srcAReg;
    ctrl.yLoad     = (step == stOpA);
    ctrl.zLoad     = (step == stOpB);
    writeIndex     = dstReg;
    loadVec        = '0;
    case (step)
      stLoadWr: begin
        ctrl.busSource  = busDatapathPkg::srcMdr;
        loadVec[dstReg] = 1'b1;
      end
      stOpB:    ctrl.regSelect = srcBReg;
      stOpLo: begin
        ctrl.busSource  = busDatapathPkg::srcZLow;
        loadVec[dstReg] = 1'b1;
      end
      stOpHi: begin
        ctrl.busSource    = busDatapathPkg::srcZHigh;
        writeIndex        = dstHiReg;
        loadVec[dstHiReg] = 1'b1;
      end
      default: ;
    endcase
  end

  assign ctrl.regLoad = loadVec;
  assign ctrl.aluOp   = opReg;
  assign writeValid   = |loadVec;
  assign mdr          = mdrReg;

endmodule

// ==== busDatapath.sv ====
// top level of the single-bus register datapath; command in, register write events out
`timescale 1ns/1ns

module busDatapath #(
  parameter int regCount = busDatapathPkg::defaultRegCount
) (
  input  logic                          clock,
  input  logic                          arstN,
  input  logic                          cmdValid,
  input  busDatapathPkg::cmdKindT       cmdKind,
  input  busDatapathPkg::aluOpT         cmdOp,
  input  logic [$clog2(regCount)-1:0]   cmdSrcA,
  input  logic [$clog2(regCount)-1:0]   cmdSrcB,
  input  logic [$clog2(regCount)-1:0]   cmdDst,
  input  logic [$clog2(regCount)-1:0]   cmdDstHi,
  input  busDatapathPkg::wordT          cmdData,
  output logic                          busy,
  output logic                          writeValid,
  output logic [$clog2(regCount)-1:0]   writeIndex,
  output busDatapathPkg::wordT          writeData
);

  busDatapathPkg::wordT regValues [regCount];
  busDatapathPkg::wordT mdr;
  busDatapathPkg::wideT zValue;

  busCtrlIf #(.regCount(regCount)) ctrlBus ();

  controlSequencer #(.regCount(regCount)) iSequencer (
    .clock      (clock),
    .arstN      (arstN),
    .cmdValid   (cmdValid),
    .cmdKind    (cmdKind),
    .cmdOp      (cmdOp),
    .cmdSrcA    (cmdSrcA),
    .cmdSrcB    (cmdSrcB),
    .cmdDst     (cmdDst),
    .cmdDstHi   (cmdDstHi),
    .cmdData    (cmdData),
    .busy       (busy),
    .ctrl       (ctrlBus.sequencer),
    .writeValid (writeValid),
    .writeIndex (writeIndex),
    .mdr        (mdr)
  );

  for (genvar i = 0; i < regCount; i++) begin : genRegs
    gpRegister iReg (
      .clock (clock),
      .arstN (arstN),
      .load  (ctrlBus.regLoad[i]),
      .bus   (ctrlBus.bus),
      .value (regValues[i])
    );
  end

  busMux #(.regCount(regCount)) iMux (
    .ctrl      (ctrlBus.mux),
    .regValues (regValues),
    .mdr       (mdr),
    .zValue    (zValue)
  );

  aluUnit iAlu (
    .clock  (clock),
    .arstN  (arstN),
    .ctrl   (ctrlBus.alu),
    .zValue (zValue)
  );

  assign writeData = ctrlBus.bus;  // bus word in a write cycle is what lands in the register

endmodule

// ==== busDatapath_properties.sv ====
// concurrent checks on the command handshake and the bus step order, bound into the datapath top
`timescale 1ns/1ns

module busDatapath_properties #(
  parameter int regCount = busDatapathPkg::defaultRegCount
) (
  input logic                    clock,
  input logic                    arstN,
  input logic                    cmdValid,
  input busDatapathPkg::cmdKindT cmdKind,
  input logic                    busy,
  input logic                    writeValid,
  input logic                    yLoad,
  input logic                    zLoad,
  input logic [regCount-1:0]     regLoad
);

  logic acceptOp;  // operate command taken on this edge

  assign acceptOp = cmdValid && !busy && (cmdKind == busDatapathPkg::cmdOperate);

  noStrobeWhileBusy: assert property (@(posedge clock) disable iff (!arstN) busy |-> !cmdValid)
    else $error("command strobe while the datapath is busy");

  noEarlyWrite: assert property (@(posedge clock) disable iff (!arstN) acceptOp |=> !writeValid)
    else $error("register write one cycle after an operate command");

  noWriteInZStep: assert property (@(posedge clock) disable iff (!arstN)
                                   acceptOp |-> ##2 !writeValid)
    else $error("register write two cycles after an operate command");

  writeAfterThree: assert property (@(posedge clock) disable iff (!arstN)
                                    acceptOp |-> ##3 writeValid)
    else $error("no register write three cycles after an operate command");

  yzExclusive: assert property (@(posedge clock) disable iff (!arstN) !(yLoad && zLoad))
    else $error("Y and Z load in the same cycle");

  loadOneHot: assert property (@(posedge clock) disable iff (!arstN) $onehot0(regLoad))
    else $error("more than one general register loads at once");

endmodule

// lands on the single datapath instance, i_dut
bind busDatapath busDatapath_properties #(.regCount(regCount)) iProps (
  .clock      (clock),
  .arstN      (arstN),
  .cmdValid   (cmdValid),
  .cmdKind    (cmdKind),
  .busy       (busy),
  .writeValid (writeValid),
  .yLoad      (ctrlBus.yLoad),
  .zLoad      (ctrlBus.zLoad),
  .regLoad    (ctrlBus.regLoad)
);

// ==== busDatapathTb.sv ====
// self-checking testbench; replays the commands of the input file and checks every register write
`timescale 1ns/1ns

module busDatapathTb;

  localparam int regCount  = busDatapathPkg::defaultRegCount;
  localparam int idxWidth  = $clog2(regCount);
  localparam int period    = 40;
  localparam int lineWords = 12;  // words per command line of the data file
  localparam int maxLines  = 64;

  logic                    clock;
  logic                    arstN;
  logic                    cmdValid;
  busDatapathPkg::cmdKindT cmdKind;
  busDatapathPkg::aluOpT   cmdOp;
  logic [idxWidth-1:0]     cmdSrcA;
  logic [idxWidth-1:0]     cmdSrcB;
  logic [idxWidth-1:0]     cmdDst;
  logic [idxWidth-1:0]     cmdDstHi;
  busDatapathPkg::wordT    cmdData;
  logic                    busy;
  logic                    writeValid;
  logic [idxWidth-1:0]     writeIndex;
  busDatapathPkg::wordT    writeData;

  logic [31:0] stim [lineWords*maxLines];
  int          lineCount;
  int          timeLimit = 0;  // watchdog span in ns once the data file is counted
  integer      seed;

  busDatapath #(.regCount(regCount)) i_dut (
    .clock      (clock),
    .arstN      (arstN),
    .cmdValid   (cmdValid),
    .cmdKind    (cmdKind),
    .cmdOp      (cmdOp),
    .cmdSrcA    (cmdSrcA),
    .cmdSrcB    (cmdSrcB),
    .cmdDst     (cmdDst),
    .cmdDstHi   (cmdDstHi),
    .cmdData    (cmdData),
    .busy       (busy),
    .writeValid (writeValid),
    .writeIndex (writeIndex),
    .writeData  (writeData)
  );

  always #(period/2) clock = ~clock;

  task automatic abortRun();
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic compareIndex(string name, logic [idxWidth-1:0] expected,
                              logic [idxWidth-1:0] actual);
    if (actual !== expected) begin
      $display("error at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
      abortRun();
    end
  endtask

  task automatic compareWord(string name, busDatapathPkg::wordT expected,
                             busDatapathPkg::wordT actual);
    if (actual !== expected) begin
      $display("error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
      abortRun();
    end
  endtask

  task automatic compareCount(string name, int expected, int actual);
    if (actual != expected) begin
      $display("error at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
      abortRun();
    end
  endtask

  // strobe one command, then follow it at each falling edge until busy drops
  task automatic runCommand(int base);
    int writesSeen;
    int cycle;
    int expCount;
    int firstCycle;
    busDatapathPkg::cmdKindT kind;
    kind       = busDatapathPkg::cmdKindT'(stim[base][0]);
    expCount   = int'(stim[base+7]);
    firstCycle = (kind == busDatapathPkg::cmdLoad) ? 1 : 3;  // load writes at once, ops after Y and Z
    writesSeen = 0;
    cycle      = 0;
    @(posedge clock);
    #2;
    cmdValid = 1'b1;
    cmdKind  = kind;
    cmdOp    = busDatapathPkg::aluOpT'(stim[base+1][4:0]);
    cmdSrcA  = stim[base+2][idxWidth-1:0];
    cmdSrcB  = stim[base+3][idxWidth-1:0];
    cmdDst   = stim[base+4][idxWidth-1:0];
    cmdDstHi = stim[base+5][idxWidth-1:0];
    cmdData  = stim[base+6];
    @(posedge clock);  // accepting edge
    #2;
    cmdValid = 1'b0;
    do begin
      @(negedge clock);
      cycle++;
      if (writeValid) begin
        if (writesSeen >= expCount) begin
          $display("a register write at %0t ns was not expected for this command", $time);
          abortRun();
        end
        compareCount("writeCycle", firstCycle + writesSeen, cycle);
        compareIndex("writeIndex", stim[base+8+2*writesSeen][idxWidth-1:0], writeIndex);
        compareWord("writeData", stim[base+9+2*writesSeen], writeData);
        writesSeen++;
      end
    end while (busy);
    compareCount("writeCount", expCount, writesSeen);
    compareCount("busy cycles", firstCycle + expCount, cycle);  // busy drops right after the last write
  endtask

  initial begin : watchdog
    wait (timeLimit > 0);
    #(timeLimit);
    $display("watchdog expired, the commands did not finish within %0d ns", timeLimit);
    abortRun();
  end

  initial begin
    int idle;
    clock    = 1'b0;
    arstN    = 1'b0;
    cmdValid = 1'b0;
    cmdKind  = busDatapathPkg::cmdLoad;
    cmdOp    = busDatapathPkg::aluAnd;
    cmdSrcA  = '0;
    cmdSrcB  = '0;
    cmdDst   = '0;
    cmdDstHi = '0;
    cmdData  = '0;
    seed     = 32'h1a16_3f4d;
    $readmemh("busDatapath_input.txt", stim);
    lineCount = 0;
    while (lineCount < maxLines && stim[lineCount*lineWords] != 32'hff) begin
      lineCount++;
    end
    if (lineCount == 0 || lineCount == maxLines) begin
      $display("the data file is missing, empty or has no end line");
      abortRun();
    end else begin
      timeLimit = (lineCount * 10 + 25) * period;  // ten cycles per command plus reset
      repeat (5) @(posedge clock);
      #2;
      arstN = 1'b1;
      for (int i = 0; i < lineCount; i++) begin
        idle = $random(seed) & 3;
        repeat (idle) @(posedge clock);
        runCommand(i * lineWords);
      end
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// ==== busDatapath_input.txt ====
// kind op srcA srcB dst dstHi data writes, then index and data of up to two writes (hex)
// kind 0 is a load and 1 an operate; a line with kind ff ends the list
0 00 0 0 1 0 00000005 1 1 00000005 0 00000000
0 00 0 0 2 0 00000002 1 2 00000002 0 00000000
0 00 0 0 3 0 00000018 1 3 00000018 0 00000000
0 00 0 0 4 0 00000018 1 4 00000018 0 00000000
0 00 0 0 5 0 00000001 1 5 00000001 0 00000000
0 00 0 0 6 0 00000005 1 6 00000005 0 00000000
0 00 0 0 7 0 00000002 1 7 00000002 0 00000000
1 05 1 5 0 0 00000000 1 0 00000001 0 00000000
1 06 1 7 0 0 00000000 1 0 00000007 0 00000000
1 04 7 6 6 0 00000000 1 6 fffffffd 0 00000000
1 03 6 1 0 0 00000000 1 0 00000002 0 00000000
1 07 3 5 0 0 00000000 1 0 0000000c 0 00000000
1 08 6 5 0 0 00000000 1 0 fffffffe 0 00000000
1 09 1 2 0 0 00000000 1 0 00000014 0 00000000
0 00 0 0 0 0 0000001f 1 0 0000001f 0 00000000
1 0b 6 0 7 0 00000000 1 7 fffffffe 0 00000000
0 00 0 0 0 0 00000040 1 0 00000040 0 00000000
1 09 1 0 7 0 00000000 1 7 00000005 0 00000000
0 00 0 0 0 0 0000003f 1 0 0000003f 0 00000000
1 09 5 0 7 0 00000000 1 7 80000000 0 00000000
1 0a 1 5 7 0 00000000 1 7 80000002 0 00000000
1 0b 7 5 7 0 00000000 1 7 00000005 0 00000000
1 11 2 2 0 0 00000000 1 0 fffffffe 0 00000000
1 12 3 3 0 0 00000000 1 0 ffffffe7 0 00000000
0 00 0 0 0 0 12345678 1 0 12345678 0 00000000
1 0f 0 6 7 6 00000000 2 7 c962fc98 6 12345677
1 10 0 1 7 6 00000000 2 7 03a4114b 6 00000001
0 00 0 0 7 0 00000000 1 7 00000000 0 00000000
1 10 0 7 6 7 00000000 2 6 ffffffff 7 12345678
1 03 6 7 0 0 00000000 1 0 12345677 0 00000000
1 06 2 3 0 0 00000000 1 0 0000001a 0 00000000
1 04 4 5 0 0 00000000 1 0 00000017 0 00000000
ff 00 0 0 0 0 00000000 0 0 00000000 0 00000000

// ==== busDatapath.f ====
busDatapathPkg.sv
busCtrlIf.sv
gpRegister.sv
busMux.sv
aluUnit.sv
controlSequencer.sv
busDatapath.sv
busDatapath_properties.sv
busDatapathTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= busDatapathTb
FILELIST  ?= busDatapath.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ns
PASSTEXT  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
	  --Mdir $(OBJDIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASSTEXT)'

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
